// File: rtl/axi_write_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_adapter #(
  parameter int NUM_NODES = 9,
  parameter int NODE_ID_W = 4,
  parameter int ID_W      = 4
) (
  input  var logic                             i_clk,
  input  var logic                             i_rst_n,
  input  var logic [NODE_ID_W-1:0]             i_node_id,
  // AXI AW channel.
  input  var logic                             i_awvalid,
  output logic                                 o_awready,
  input  var logic [ID_W-1:0]                  i_awid,
  input  var logic [31:0]                      i_awaddr,
  input  var logic [7:0]                       i_awlen,
  input  var logic [2:0]                       i_awsize,
  // AXI W channel.
  input  var logic                             i_wvalid,
  output logic                                 o_wready,
  input  var logic [wadp_pkg::AXI_DATA_W-1:0]  i_wdata,
  input  var logic [wadp_pkg::AXI_STRB_W-1:0]  i_wstrb,
  input  var logic                             i_wlast,
  // AXI B channel.
  output logic                                 o_bvalid,
  input  var logic                             i_bready,
  output logic [ID_W-1:0]                      o_bid,
  output wadp_pkg::resp_status_e               o_bresp,
  // flits towards the network.
  output logic                                 o_flit_valid,
  input  var logic                             i_flit_ready,
  output wadp_pkg::flit_kind_e                 o_flit_kind,
  output logic [wadp_pkg::FLIT_DATA_W-1:0]     o_flit_data,
  output logic [wadp_pkg::FLIT_BE_W-1:0]       o_flit_be,
  output logic                                 o_flit_last,
  // response flits from the network.
  input  var logic                             i_resp_valid,
  output logic                                 o_resp_ready,
  input  var logic [wadp_pkg::FLIT_DATA_W-1:0] i_resp_data
);

  logic                             hdr_valid;
  logic                             hdr_ready;
  wadp_pkg::flit_kind_e             hdr_kind;
  logic [31:0]                      hdr_data;
  logic                             pay_valid;
  logic                             pay_ready;
  logic [wadp_pkg::FLIT_DATA_W-1:0] pay_data;
  logic [wadp_pkg::FLIT_BE_W-1:0]   pay_be;
  logic                             pay_last;

  wadp_header_gen #(
    .NUM_NODES (NUM_NODES),
    .NODE_ID_W (NODE_ID_W),
    .ID_W      (ID_W)
  ) header_gen_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_node_id   (i_node_id),
    .i_awvalid   (i_awvalid),
    .o_awready   (o_awready),
    .i_awid      (i_awid),
    .i_awaddr    (i_awaddr),
    .i_awlen     (i_awlen),
    .i_awsize    (i_awsize),
    .o_hdr_valid (hdr_valid),
    .i_hdr_ready (hdr_ready),
    .o_hdr_kind  (hdr_kind),
    .o_hdr_data  (hdr_data)
  );

  wadp_payload_pack payload_pack_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wvalid    (i_wvalid),
    .o_wready    (o_wready),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_wlast     (i_wlast),
    .o_pay_valid (pay_valid),
    .i_pay_ready (pay_ready),
    .o_pay_data  (pay_data),
    .o_pay_be    (pay_be),
    .o_pay_last  (pay_last)
  );

  wadp_flit_merge flit_merge_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_hdr_valid  (hdr_valid),
    .o_hdr_ready  (hdr_ready),
    .i_hdr_kind   (hdr_kind),
    .i_hdr_data   (hdr_data),
    .i_pay_valid  (pay_valid),
    .o_pay_ready  (pay_ready),
    .i_pay_data   (pay_data),
    .i_pay_be     (pay_be),
    .i_pay_last   (pay_last),
    .o_flit_valid (o_flit_valid),
    .i_flit_ready (i_flit_ready),
    .o_flit_kind  (o_flit_kind),
    .o_flit_data  (o_flit_data),
    .o_flit_be    (o_flit_be),
    .o_flit_last  (o_flit_last)
  );

  wadp_resp_unit #(
    .ID_W (ID_W)
  ) resp_unit_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_resp_valid (i_resp_valid),
    .o_resp_ready (o_resp_ready),
    .i_resp_data  (i_resp_data),
    .o_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .o_bid        (o_bid),
    .o_bresp      (o_bresp)
  );

endmodule

`default_nettype wire

// File: rtl/wadp_flit_merge.sv
`timescale 1ns/1ps
`default_nettype none

module wadp_flit_merge (
  input  var logic                             i_clk,
  input  var logic                             i_rst_n,
  input  var logic                             i_hdr_valid,
  output logic                                 o_hdr_ready,
  input  var wadp_pkg::flit_kind_e             i_hdr_kind,
  input  var logic [wadp_pkg::FLIT_DATA_W-1:0] i_hdr_data,
  input  var logic                             i_pay_valid,
  output logic                                 o_pay_ready,
  input  var logic [wadp_pkg::FLIT_DATA_W-1:0] i_pay_data,
  input  var logic [wadp_pkg::FLIT_BE_W-1:0]   i_pay_be,
  input  var logic                             i_pay_last,
  output logic                                 o_flit_valid,
  input  var logic                             i_flit_ready,
  output wadp_pkg::flit_kind_e                 o_flit_kind,
  output logic [wadp_pkg::FLIT_DATA_W-1:0]     o_flit_data,
  output logic [wadp_pkg::FLIT_BE_W-1:0]       o_flit_be,
  output logic                                 o_flit_last
);

  wadp_pkg::merge_state_e state;
  wadp_pkg::merge_state_e state_nxt;

  wire flit_take = o_flit_valid && i_flit_ready;

  always_comb begin
    o_hdr_ready  = 1'b0;
    o_pay_ready  = 1'b0;
    o_flit_valid = i_hdr_valid;
    o_flit_kind  = i_hdr_kind;
    o_flit_data  = i_hdr_data;
    o_flit_be    = '1; // header words are always full.
    o_flit_last  = 1'b0;
    state_nxt    = state;
    case (state)
      wadp_pkg::MERGE_HEAD: begin
        o_hdr_ready = i_flit_ready;
        if (flit_take) state_nxt = wadp_pkg::MERGE_ADDR;
      end
      wadp_pkg::MERGE_ADDR: begin
        o_hdr_ready = i_flit_ready;
        if (flit_take) state_nxt = wadp_pkg::MERGE_DATA;
      end
      wadp_pkg::MERGE_DATA: begin
        o_pay_ready  = i_flit_ready;
        o_flit_valid = i_pay_valid;
        o_flit_kind  = wadp_pkg::FLIT_DATA;
        o_flit_data  = i_pay_data;
        o_flit_be    = i_pay_be;
        o_flit_last  = i_pay_last;
        if (flit_take && i_pay_last) state_nxt = wadp_pkg::MERGE_HEAD;
      end
      default: state_nxt = wadp_pkg::MERGE_HEAD;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) state <= wadp_pkg::MERGE_HEAD;
    else          state <= state_nxt;
  end

  // the header builder must be pointing at its head word whenever a new
  // packet starts.
  a_head_first: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (state == wadp_pkg::MERGE_HEAD && flit_take) |-> (o_flit_kind == wadp_pkg::FLIT_HEAD));

endmodule

`default_nettype wire

// File: rtl/wadp_header_gen.sv
`timescale 1ns/1ps
`default_nettype none

module wadp_header_gen #(
  parameter int NUM_NODES = 9,
  parameter int NODE_ID_W = 4,
  parameter int ID_W      = 4
) (
  input  var logic                 i_clk,
  input  var logic                 i_rst_n,
  input  var logic [NODE_ID_W-1:0] i_node_id,
  input  var logic                 i_awvalid,
  output logic                     o_awready,
  input  var logic [ID_W-1:0]      i_awid,
  input  var logic [31:0]          i_awaddr,
  input  var logic [7:0]           i_awlen,
  input  var logic [2:0]           i_awsize,
  output logic                     o_hdr_valid,
  input  var logic                 i_hdr_ready,
  output wadp_pkg::flit_kind_e     o_hdr_kind,
  output logic [31:0]              o_hdr_data
);

  logic            aw_full;
  logic            word_sel; // 0 selects the head flit, 1 the address flit.
  logic [ID_W-1:0] id_q;
  logic [31:0]     addr_q;
  logic [7:0]      len_q;
  logic [2:0]      size_q;
  logic [3:0]      dest_q;
  logic            inv_q;

  wire aw_take  = i_awvalid && o_awready;
  wire hdr_take = o_hdr_valid && i_hdr_ready;

  assign o_awready = !aw_full;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      aw_full  <= 1'b0;
      word_sel <= 1'b0;
    end else if (aw_take) begin
      aw_full  <= 1'b1;
      word_sel <= 1'b0;
    end else if (hdr_take) begin
      aw_full  <= !word_sel; // the slot frees once the address flit has left.
      word_sel <= !word_sel;
    end
  end

  always_ff @(posedge i_clk) begin
    if (aw_take) begin
      id_q   <= i_awid;
      addr_q <= i_awaddr & ~((32'h1 << i_awsize) - 32'h1);
      len_q  <= i_awlen;
      size_q <= i_awsize;
      dest_q <= i_awaddr[31:28];
      inv_q  <= (int'(i_awaddr[31:28]) >= NUM_NODES);
    end
  end

  assign o_hdr_valid = aw_full;
  assign o_hdr_kind  = word_sel ? wadp_pkg::FLIT_ADDR : wadp_pkg::FLIT_HEAD;
  assign o_hdr_data  = word_sel ? addr_q
                                : {8'h00, inv_q, size_q, len_q, 4'(id_q), 4'(i_node_id), dest_q};

  // a stalled header flit must not change under the merger.
  a_hdr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_hdr_valid && !i_hdr_ready) |=> (o_hdr_valid && $stable(o_hdr_data)));

endmodule

`default_nettype wire

// File: rtl/wadp_payload_pack.sv
`timescale 1ns/1ps
`default_nettype none

module wadp_payload_pack (
  input  var logic                            i_clk,
  input  var logic                            i_rst_n,
  input  var logic                            i_wvalid,
  output logic                                o_wready,
  input  var logic [wadp_pkg::AXI_DATA_W-1:0] i_wdata,
  input  var logic [wadp_pkg::AXI_STRB_W-1:0] i_wstrb,
  input  var logic                            i_wlast,
  output logic                                o_pay_valid,
  input  var logic                            i_pay_ready,
  output logic [wadp_pkg::FLIT_DATA_W-1:0]    o_pay_data,
  output logic [wadp_pkg::FLIT_BE_W-1:0]      o_pay_be,
  output logic                                o_pay_last
);

  // ####################################################################
  // one-beat buffer
  // ####################################################################

  logic                            buf_full;
  logic                            half_sel; // high half goes out when set.
  logic [wadp_pkg::AXI_DATA_W-1:0] data_q;
  logic [wadp_pkg::AXI_STRB_W-1:0] strb_q;
  logic                            last_q;

  wire pay_take = o_pay_valid && i_pay_ready;
  wire w_take   = i_wvalid && o_wready;

  // The buffer counts as empty on the cycle its high half leaves, so a
  // fresh beat can land right behind it and each beat costs two flit cycles.
  assign o_wready = !buf_full || (half_sel && i_pay_ready);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      buf_full <= 1'b0;
      half_sel <= 1'b0;
    end else if (w_take) begin
      buf_full <= 1'b1;
      half_sel <= 1'b0;
    end else if (pay_take) begin
      buf_full <= !half_sel;
      half_sel <= !half_sel;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_take) begin
      data_q <= i_wdata;
      strb_q <= i_wstrb;
      last_q <= i_wlast;
    end
  end

  // ####################################################################
  // half select
  // ####################################################################

  assign o_pay_valid = buf_full;
  assign o_pay_data  = half_sel ? data_q[63:32] : data_q[31:0];
  assign o_pay_be    = half_sel ? strb_q[7:4] : strb_q[3:0];
  assign o_pay_last  = half_sel && last_q;

  // a stalled half must not be overwritten by a new W beat.
  a_pay_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_pay_valid && !i_pay_ready) |=>
      (o_pay_valid && $stable(o_pay_data) && $stable(o_pay_be) && $stable(o_pay_last)));

endmodule

`default_nettype wire

// File: rtl/wadp_pkg.sv
`default_nettype none

package wadp_pkg;

  // ####################################################################
  // flit encodings
  // ####################################################################

  typedef enum logic [1:0] {
    FLIT_HEAD = 2'd0,
    FLIT_ADDR = 2'd1,
    FLIT_DATA = 2'd2,
    FLIT_RESP = 2'd3
  } flit_kind_e;

  // head flit layout, all fields packed from bit 0 upwards.
  //   [3:0]   destination node.
  //   [7:4]   source node.
  //   [11:8]  tag, taken from awid.
  //   [19:12] awlen.
  //   [22:20] awsize.
  //   [23]    invalid destination flag.
  // the address flit carries the aligned awaddr in all 32 bits.
  // response flit: [3:0] tag, [5:4] status.

  localparam int FLIT_DATA_W = 32;
  localparam int FLIT_BE_W   = 4;

  // ####################################################################
  // AXI side
  // ####################################################################

  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = 8;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_status_e;

  // ####################################################################
  // merge control
  // ####################################################################

  typedef enum logic [1:0] {
    MERGE_HEAD,
    MERGE_ADDR,
    MERGE_DATA
  } merge_state_e;

endpackage

`default_nettype wire

// File: rtl/wadp_resp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module wadp_resp_unit #(
  parameter int ID_W = 4
) (
  input  var logic                             i_clk,
  input  var logic                             i_rst_n,
  input  var logic                             i_resp_valid,
  output logic                                 o_resp_ready,
  input  var logic [wadp_pkg::FLIT_DATA_W-1:0] i_resp_data,
  output logic                                 o_bvalid,
  input  var logic                             i_bready,
  output logic [ID_W-1:0]                      o_bid,
  output wadp_pkg::resp_status_e               o_bresp
);

  logic                   b_full;
  logic [ID_W-1:0]        bid_q;
  wadp_pkg::resp_status_e bresp_q;

  // Status 1 is reserved on the network and reported as a slave error.
  function automatic wadp_pkg::resp_status_e map_status(input logic [1:0] status);
    case (status)
      2'd0:    return wadp_pkg::RESP_OKAY;
      2'd3:    return wadp_pkg::RESP_DECERR;
      default: return wadp_pkg::RESP_SLVERR;
    endcase
  endfunction

  wire resp_take = i_resp_valid && o_resp_ready;

  assign o_resp_ready = !b_full;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n)                 b_full <= 1'b0;
    else if (resp_take)           b_full <= 1'b1;
    else if (o_bvalid && i_bready) b_full <= 1'b0;
  end

  always_ff @(posedge i_clk) begin
    if (resp_take) begin
      bid_q   <= ID_W'(i_resp_data[3:0]);
      bresp_q <= map_status(i_resp_data[5:4]);
    end
  end

  assign o_bvalid = b_full;
  assign o_bid    = bid_q;
  assign o_bresp  = bresp_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_axi_write_adapter -Mdir "$BUILD_DIR" -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_axi_write_adapter" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

// File: sim.f
+incdir+verification
rtl/wadp_pkg.sv
rtl/wadp_header_gen.sv
rtl/wadp_payload_pack.sv
rtl/wadp_flit_merge.sv
rtl/wadp_resp_unit.sv
rtl/axi_write_adapter.sv
verification/tb_axi_write_adapter.sv

// File: verification/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ####################################################################
// drivers
// ####################################################################

task automatic send_aw(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len);
  bit hit;
  i_awvalid = 1'b1;
  i_awid    = id;
  i_awaddr  = addr;
  i_awlen   = len;
  i_awsize  = 3'd3; // full 64-bit beats only.
  do begin
    @(negedge i_clk);
    hit = o_awready;
    @(posedge i_clk);
    #DRIVE_DLY;
  end while (!hit);
  i_awvalid = 1'b0;
endtask

task automatic send_w(input int first, input int n);
  bit hit;
  for (int i = 0; i < n; i++) begin
    i_wvalid = 1'b1;
    i_wdata  = beat_data[first+i];
    i_wstrb  = beat_strb[first+i];
    i_wlast  = (i == n - 1);
    do begin
      @(negedge i_clk);
      hit = o_wready;
      @(posedge i_clk);
      #DRIVE_DLY;
    end while (!hit);
  end
  i_wvalid = 1'b0;
  i_wlast  = 1'b0;
endtask

task automatic send_resp(input logic [3:0] tag, input logic [1:0] status);
  bit hit;
  i_resp_valid = 1'b1;
  i_resp_data  = {26'd0, status, tag};
  do begin
    @(negedge i_clk);
    hit = o_resp_ready;
    @(posedge i_clk);
    #DRIVE_DLY;
  end while (!hit);
  i_resp_valid = 1'b0;
endtask

// holds bready low for a while, then takes the response.
task automatic take_b(input logic [3:0] tag, input wadp_pkg::resp_status_e resp,
                      input int stall);
  i_bready = 1'b0;
  repeat (stall) begin
    @(negedge i_clk);
    check_bit("o_bvalid", 1'b1, o_bvalid);
    check_b(tag, resp);
    check_bit("o_resp_ready", 1'b0, o_resp_ready);
    @(posedge i_clk);
    #DRIVE_DLY;
  end
  i_bready = 1'b1;
  @(negedge i_clk);
  check_bit("o_bvalid", 1'b1, o_bvalid);
  check_b(tag, resp);
  @(posedge i_clk);
  #DRIVE_DLY;
  i_bready = 1'b0;
endtask

task automatic toggle_flit_ready();
  logic [31:0] r;
  while (!collect_done) begin
    r            = next_rand();
    i_flit_ready = r[0] | r[1]; // ready on about three cycles in four.
    @(posedge i_clk);
    #DRIVE_DLY;
  end
  i_flit_ready = 1'b1;
endtask

// ####################################################################
// expected flits
// ####################################################################

function automatic void expect_burst(input logic [3:0] id, input logic [31:0] addr,
                                     input logic [7:0] len, input int first);
  logic [31:0] head;
  logic [3:0]  dest;
  logic [63:0] d;
  logic [7:0]  s;
  dest        = addr[31:28];
  head        = '0;
  head[3:0]   = dest;
  head[7:4]   = NODE_ID;
  head[11:8]  = id;
  head[19:12] = len;
  head[22:20] = 3'd3;
  head[23]    = (int'(dest) >= NUM_NODES); // only nodes 0 to 8 exist.
  exp_q.push_back({wadp_pkg::FLIT_HEAD, head, 4'hf, 1'b0});
  exp_q.push_back({wadp_pkg::FLIT_ADDR, addr & 32'hffff_fff8, 4'hf, 1'b0});
  for (int i = 0; i <= int'(len); i++) begin
    d = beat_data[first+i];
    s = beat_strb[first+i];
    exp_q.push_back({wadp_pkg::FLIT_DATA, d[31:0], s[3:0], 1'b0});
    exp_q.push_back({wadp_pkg::FLIT_DATA, d[63:32], s[7:4], (i == int'(len))});
  end
endfunction

task automatic collect_flits();
  logic [38:0] e;
  while (exp_q.size() > 0) begin
    @(negedge i_clk);
    if (o_flit_valid && i_flit_ready) begin
      e = exp_q.pop_front();
      check_flit(wadp_pkg::flit_kind_e'(e[38:37]), e[36:5], e[4:1], e[0]);
    end
  end
  collect_done = 1'b1;
  @(posedge i_clk);
  #DRIVE_DLY;
endtask

// runs the queued bursts with AW, W and the flit collector side by side.
task automatic run_bursts(input int nb, input bit stall);
  int w_first;
  w_first      = 0;
  collect_done = 1'b0;
  for (int b = 0; b < nb; b++) begin
    expect_burst(b_id[b], b_addr[b], b_len[b], w_first);
    w_first += int'(b_len[b]) + 1;
  end
  w_first = 0;
  fork
    begin
      for (int b = 0; b < nb; b++) send_aw(b_id[b], b_addr[b], b_len[b]);
    end
    begin
      for (int b = 0; b < nb; b++) begin
        send_w(w_first, int'(b_len[b]) + 1);
        w_first += int'(b_len[b]) + 1;
      end
    end
    collect_flits();
    if (stall) toggle_flit_ready();
  join
endtask

// ####################################################################
// compare tasks
// ####################################################################

task automatic check_flit(input wadp_pkg::flit_kind_e kind, input logic [31:0] data,
                          input logic [3:0] be, input logic last);
  if (o_flit_kind !== kind) begin
    $display("[FAIL] %0t o_flit_kind expected %s got %s", $time, kind.name(),
             o_flit_kind.name());
    stop_run();
  end
  if (o_flit_data !== data) begin
    $display("[FAIL] %0t o_flit_data expected %h got %h", $time, data, o_flit_data);
    stop_run();
  end
  if (o_flit_be !== be) begin
    $display("[FAIL] %0t o_flit_be expected %h got %h", $time, be, o_flit_be);
    stop_run();
  end
  if (o_flit_last !== last) begin
    $display("[FAIL] %0t o_flit_last expected %b got %b", $time, last, o_flit_last);
    stop_run();
  end
endtask

task automatic check_b(input logic [3:0] id, input wadp_pkg::resp_status_e resp);
  if (o_bid !== id) begin
    $display("[FAIL] %0t o_bid expected %h got %h", $time, id, o_bid);
    stop_run();
  end
  if (o_bresp !== resp) begin
    $display("[FAIL] %0t o_bresp expected %0d got %0d", $time, resp, o_bresp);
    stop_run();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
  if (got !== exp) begin
    $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
    stop_run();
  end
endtask

`endif

// File: verification/tb_axi_write_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_adapter;

  localparam int         NUM_TESTS = 6;
  localparam int         NUM_NODES = 9;
  localparam logic [3:0] NODE_ID   = 4'd5;
  localparam int         DRIVE_DLY = 2;

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_awvalid;
  logic                   o_awready;
  logic [3:0]             i_awid;
  logic [31:0]            i_awaddr;
  logic [7:0]             i_awlen;
  logic [2:0]             i_awsize;
  logic                   i_wvalid;
  logic                   o_wready;
  logic [63:0]            i_wdata;
  logic [7:0]             i_wstrb;
  logic                   i_wlast;
  logic                   o_bvalid;
  logic                   i_bready;
  logic [3:0]             o_bid;
  wadp_pkg::resp_status_e o_bresp;
  logic                   o_flit_valid;
  logic                   i_flit_ready;
  wadp_pkg::flit_kind_e   o_flit_kind;
  logic [31:0]            o_flit_data;
  logic [3:0]             o_flit_be;
  logic                   o_flit_last;
  logic                   i_resp_valid;
  logic                   o_resp_ready;
  logic [31:0]            i_resp_data;

  logic [31:0] rng_state = 32'h0fe88013;
  logic [63:0] beat_data [$];
  logic [7:0]  beat_strb [$];
  logic [3:0]  b_id [$];
  logic [31:0] b_addr [$];
  logic [7:0]  b_len [$];
  logic [38:0] exp_q [$]; // {kind, data, be, last} of each flit still to come.
  logic        collect_done;

  axi_write_adapter axi_write_adapter_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_node_id    (NODE_ID),
    .i_awvalid    (i_awvalid),
    .o_awready    (o_awready),
    .i_awid       (i_awid),
    .i_awaddr     (i_awaddr),
    .i_awlen      (i_awlen),
    .i_awsize     (i_awsize),
    .i_wvalid     (i_wvalid),
    .o_wready     (o_wready),
    .i_wdata      (i_wdata),
    .i_wstrb      (i_wstrb),
    .i_wlast      (i_wlast),
    .o_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .o_bid        (o_bid),
    .o_bresp      (o_bresp),
    .o_flit_valid (o_flit_valid),
    .i_flit_ready (i_flit_ready),
    .o_flit_kind  (o_flit_kind),
    .o_flit_data  (o_flit_data),
    .o_flit_be    (o_flit_be),
    .o_flit_last  (o_flit_last),
    .i_resp_valid (i_resp_valid),
    .o_resp_ready (o_resp_ready),
    .i_resp_data  (i_resp_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  `include "tb_tasks.svh"

  // ####################################################################
  // tests
  // ####################################################################

  task automatic new_burst(input logic [3:0] id, input logic [31:0] addr, input int beats);
    logic [31:0] r1;
    logic [31:0] r2;
    b_id.push_back(id);
    b_addr.push_back(addr);
    b_len.push_back(8'(beats - 1));
    for (int i = 0; i < beats; i++) begin
      r1 = next_rand();
      r2 = next_rand();
      beat_data.push_back({r1, r2});
      beat_strb.push_back(r2[7:0] & 8'h7e); // outer bytes off, so every beat is partial.
    end
  endtask

  task automatic clear_bursts();
    beat_data.delete();
    beat_strb.delete();
    b_id.delete();
    b_addr.delete();
    b_len.delete();
  endtask

  task automatic reset_outputs();
    @(negedge i_clk);
    check_bit("o_awready", 1'b1, o_awready);
    check_bit("o_wready", 1'b1, o_wready);
    check_bit("o_flit_valid", 1'b0, o_flit_valid);
    check_bit("o_bvalid", 1'b0, o_bvalid);
    check_bit("o_resp_ready", 1'b1, o_resp_ready);
    @(posedge i_clk);
    #DRIVE_DLY;
  endtask

  task automatic single_beat_write();
    clear_bursts();
    new_burst(4'h6, 32'h3000_0040, 1);
    beat_data[0] = 64'h8877_6655_4433_2211;
    beat_strb[0] = 8'hff;
    run_bursts(1, 1'b0);
  endtask

  task automatic partial_strobe_burst();
    clear_bursts();
    new_burst(4'ha, 32'h2000_1000, 4);
    run_bursts(1, 1'b0);
  endtask

  task automatic invalid_dest_write();
    // node 12 lies outside the 3x3 mesh.
    clear_bursts();
    new_burst(4'h3, 32'hc000_0200, 2);
    run_bursts(1, 1'b0);
  endtask

  task automatic stalled_bursts();
    clear_bursts();
    new_burst(4'h1, 32'h7000_0800, 3);
    new_burst(4'h2, 32'h1000_0010, 5);
    run_bursts(2, 1'b1);
  endtask

  task automatic response_codes();
    wadp_pkg::resp_status_e exp_resp [$];
    logic [31:0]            r;
    exp_resp.push_back(wadp_pkg::RESP_OKAY);
    exp_resp.push_back(wadp_pkg::RESP_SLVERR); // status 1 is reserved.
    exp_resp.push_back(wadp_pkg::RESP_SLVERR);
    exp_resp.push_back(wadp_pkg::RESP_DECERR);
    for (int st = 0; st < 4; st++) begin
      r = next_rand();
      send_resp(r[3:0], 2'(st));
      take_b(r[3:0], exp_resp[st], int'(r[7:4]) % 6);
    end
  endtask

  initial begin
    i_rst_n      = 1'b0;
    i_awvalid    = 1'b0;
    i_awid       = '0;
    i_awaddr     = '0;
    i_awlen      = '0;
    i_awsize     = '0;
    i_wvalid     = 1'b0;
    i_wdata      = '0;
    i_wstrb      = '0;
    i_wlast      = 1'b0;
    i_bready     = 1'b0;
    i_flit_ready = 1'b1;
    i_resp_valid = 1'b0;
    i_resp_data  = '0;
    collect_done = 1'b0;
    repeat (4) @(posedge i_clk);
    #DRIVE_DLY;
    i_rst_n = 1'b1;

    reset_outputs();
    single_beat_write();
    partial_strobe_burst();
    invalid_dest_write();
    stalled_bursts();
    response_codes();

    @(negedge i_clk);
    check_bit("o_flit_valid", 1'b0, o_flit_valid);
    $display("TB PASSED");
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge i_clk);
    $display("timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
    stop_run();
  end

endmodule

`default_nettype wire
